/* sources.f */
src/t2t_pkg.sv
src/strategy_regs.sv
src/threshold_cmp.sv
src/strategy_fsm.sv
src/order_stamp.sv
src/strategy_engine.sv
sim/tb_strategy_engine.sv

/* Makefile */
# Verilator build and run of the strategy engine testbench.
# Any variable below can be overridden, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_strategy_engine
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SOME TESTS FAILED

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation clean, see $(LOG)"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_strategy_engine.sv */
// --------------------------------------
// Testbench for the strategy engine.
// Writes random symbol settings, sends
// random decoder traffic and checks each
// order against a strategy model.
// --------------------------------------

module tb_strategy_engine
  import t2t_pkg::*;
();

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 16;
  localparam int          BURST_LEN    = 200;
  localparam int          NUM_BURSTS   = 3;
  localparam logic [31:0] SEED         = 32'h5a934def;
  // Per-event budget covers gaps, compare cycle and order stalls
  localparam int          TIMEOUT_CYCLES = (NUM_BURSTS * BURST_LEN + 200) * 40;
  // Expected order packed as {id, sym, price, qty}
  localparam int          EXP_W = OID_W + SYM_W + PRICE_W + VOL_W;

  logic               clk;
  logic               reset_n;
  logic               cfg_wr;
  logic [SYM_W-1:0]   cfg_sym;
  cfg_field_e         cfg_field;
  logic [DATA_W-1:0]  cfg_wdata;
  logic               dec_valid;
  logic               dec_sop;
  logic [DATA_W-1:0]  dec_data;
  logic               dec_ready;
  logic               order_ready;
  logic               order_valid;
  logic [OID_W-1:0]   order_id;
  logic [SYM_W-1:0]   order_sym;
  logic [PRICE_W-1:0] order_price;
  logic [VOL_W-1:0]   order_qty;

  // Model copy of the settings table
  logic               m_enable [NUM_SYM];
  logic [PRICE_W-1:0] m_limit  [NUM_SYM];
  logic [VOL_W-1:0]   m_minvol [NUM_SYM];
  logic [VOL_W-1:0]   m_qty    [NUM_SYM];
  logic [EXP_W-1:0]   exp_q [$];
  logic [OID_W-1:0]   next_id;

  logic [31:0]        stim_lfsr;
  logic [31:0]        rdy_lfsr;
  logic               bp_on;
  logic               after_trunc;
  int                 mismatch_cnt;
  int                 other_cnt;
  // Monitor state for a stalled order
  logic               hold_vld = 1'b0;
  logic [EXP_W-1:0]   hold_fields;

  strategy_engine u_dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_wr      (cfg_wr),
    .cfg_sym     (cfg_sym),
    .cfg_field   (cfg_field),
    .cfg_wdata   (cfg_wdata),
    .dec_valid   (dec_valid),
    .dec_sop     (dec_sop),
    .dec_data    (dec_data),
    .dec_ready   (dec_ready),
    .order_ready (order_ready),
    .order_valid (order_valid),
    .order_id    (order_id),
    .order_sym   (order_sym),
    .order_price (order_price),
    .order_qty   (order_qty)
  );

  // --------------------------------------
  // Random source and checks
  // --------------------------------------

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      val = {val[30:0], stim_lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s at %0t", msg, $time);
    other_cnt++;
  endtask

  task automatic compare_order(input logic [EXP_W-1:0] got, input logic [EXP_W-1:0] want);
    check_val("order_id", 32'(got[EXP_W-1 -: OID_W]), 32'(want[EXP_W-1 -: OID_W]));
    check_val("order_sym", 32'(got[PRICE_W+VOL_W +: SYM_W]), 32'(want[PRICE_W+VOL_W +: SYM_W]));
    check_val("order_price", 32'(got[VOL_W +: PRICE_W]), 32'(want[VOL_W +: PRICE_W]));
    check_val("order_qty", 32'(got[VOL_W-1:0]), 32'(want[VOL_W-1:0]));
  endtask

  // --------------------------------------
  // Stimulus tasks
  // --------------------------------------

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic cfg_write(input logic [SYM_W-1:0] sym, input cfg_field_e fld,
                           input logic [DATA_W-1:0] data);
    cfg_wr    = 1'b1;
    cfg_sym   = sym;
    cfg_field = fld;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  // New random settings with the enable set three times in four
  task automatic config_symbol(input logic [SYM_W-1:0] sym);
    m_enable[sym] = (rand_bits(2) != 0);
    m_limit[sym]  = PRICE_W'(rand_bits(PRICE_W));
    m_minvol[sym] = VOL_W'(rand_bits(VOL_W));
    m_qty[sym]    = VOL_W'(rand_bits(VOL_W));
    cfg_write(sym, FLD_ENABLE, {31'd0, m_enable[sym]});
    cfg_write(sym, FLD_PRICE_LIMIT, 32'(m_limit[sym]));
    cfg_write(sym, FLD_MIN_VOLUME, 32'(m_minvol[sym]));
    cfg_write(sym, FLD_ORDER_QTY, 32'(m_qty[sym]));
  endtask

  // Holds the beat until the DUT takes it
  task automatic send_beat(input logic sop, input logic [DATA_W-1:0] data);
    dec_valid = 1'b1;
    dec_sop   = sop;
    dec_data  = data;
    @(posedge clk);
    while (!dec_ready) @(posedge clk);
    #1;
    dec_valid = 1'b0;
    // Junk on the bus between beats
    dec_data = rand_bits(DATA_W);
  endtask

  // Beat 1, optional beat 2, and the model's verdict
  task automatic send_packet(input msg_type_e mt, input logic [SYM_W-1:0] sym,
                             input logic [PRICE_W-1:0] price, input logic [VOL_W-1:0] vol,
                             input logic full);
    logic [DATA_W-1:0] beat1;
    logic [DATA_W-1:0] beat2;
    logic [VOL_W-1:0]  qty;
    beat1 = rand_bits(DATA_W);
    beat1[MSG_TYPE_HI:MSG_TYPE_LO] = mt;
    beat1[SYM_HI:SYM_LO] = sym;
    beat1[PRICE_W-1:0] = price;
    beat2 = rand_bits(DATA_W);
    beat2[VOL_W-1:0] = vol;
    send_beat(1'b1, beat1);
    if (full) begin
      if (rand_bits(2) == 0) idle(1);
      send_beat(1'b0, beat2);
      // Strategy rule: NEW, enabled, price at or under limit, volume at or over minimum
      if (mt == MSG_NEW && m_enable[sym] && price <= m_limit[sym] &&
          vol >= m_minvol[sym]) begin
        qty = (vol < m_qty[sym]) ? vol : m_qty[sym];
        exp_q.push_back({next_id, sym, price, qty});
        next_id++;
      end
    end
  endtask

  task automatic send_event();
    logic [31:0]       kind;
    logic [31:0]       r;
    logic [SYM_W-1:0]  sym;
    logic [PRICE_W-1:0] price;
    logic [VOL_W-1:0]  vol;
    msg_type_e         mt;
    kind  = rand_bits(3);
    sym   = SYM_W'(rand_bits(SYM_W));
    price = PRICE_W'(rand_bits(PRICE_W));
    vol   = VOL_W'(rand_bits(VOL_W));
    // A cut-off packet must be followed by a fresh beat 1
    if (after_trunc && kind >= 6) kind = 0;
    after_trunc = 1'b0;
    // Boundary case with price at the limit and volume at the minimum
    if (kind == 4) begin
      price = m_limit[sym];
      vol   = m_minvol[sym];
    end
    case (kind)
      5: begin
        r  = rand_bits(2);
        mt = (r[1:0] == 2'd0) ? MSG_OTHER : msg_type_e'(r[1:0]);
        send_packet(mt, sym, price, vol, 1'b1);
      end
      6: send_beat(1'b0, rand_bits(DATA_W));
      7: begin
        send_packet(MSG_NEW, sym, price, vol, 1'b0);
        after_trunc = 1'b1;
      end
      default: send_packet(MSG_NEW, sym, price, vol, 1'b1);
    endcase
    if (rand_bits(2) == 0) idle(1);
  endtask

  // Bounded wait for pending orders, then a few quiet cycles
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 64) begin
      idle(1);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected orders never appeared", exp_q.size()));
      exp_q.delete();
    end
    idle(4);
  endtask

  task automatic run_burst(input int n);
    for (int i = 0; i < n; i++) begin
      send_event();
    end
    while (after_trunc) send_event();
    drain();
  endtask

  // --------------------------------------
  // Clock, order_ready and watchdog
  // --------------------------------------

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Random back-pressure when enabled
  initial begin
    order_ready = 1'b1;
    rdy_lfsr    = SEED;
    forever begin
      @(posedge clk);
      #1;
      rdy_lfsr    = lfsr_step(rdy_lfsr);
      order_ready = bp_on ? rdy_lfsr[0] : 1'b1;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------
  // Order monitor
  // --------------------------------------

  always @(posedge clk) begin
    logic [EXP_W-1:0] cur;
    logic [EXP_W-1:0] want;
    cur = {order_id, order_sym, order_price, order_qty};
    if (reset_n && order_valid) begin
      // Decoder stalled while an order is pending
      check_val("dec_ready", 32'(dec_ready), 32'd0);
      if (hold_vld) compare_order(cur, hold_fields);
      if (order_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("order accepted with none expected");
        end else begin
          want = exp_q.pop_front();
          compare_order(cur, want);
        end
        hold_vld = 1'b0;
      end else begin
        hold_vld    = 1'b1;
        hold_fields = cur;
      end
    end else begin
      if (hold_vld) report_failure("order withdrawn before it was accepted");
      hold_vld = 1'b0;
    end
  end

  // --------------------------------------
  // Main sequence
  // --------------------------------------

  initial begin
    reset_n      = 1'b0;
    cfg_wr       = 1'b0;
    cfg_sym      = '0;
    cfg_field    = FLD_ENABLE;
    cfg_wdata    = '0;
    dec_valid    = 1'b0;
    dec_sop      = 1'b0;
    dec_data     = '0;
    stim_lfsr    = SEED;
    bp_on        = 1'b0;
    after_trunc  = 1'b0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    next_id      = '0;
    for (int s = 0; s < NUM_SYM; s++) begin
      m_enable[s] = 1'b0;
      m_limit[s]  = '0;
      m_minvol[s] = '0;
      m_qty[s]    = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_val("order_valid", 32'(order_valid), 32'd0);
    check_val("dec_ready", 32'(dec_ready), 32'd1);

    // Zero limits pass these packets and only the enable bit blocks them
    for (int s = 0; s < NUM_SYM; s++) begin
      send_packet(MSG_NEW, SYM_W'(s), '0, '1, 1'b1);
    end
    drain();

    // Burst with order_ready held high
    for (int s = 0; s < NUM_SYM; s++) begin
      config_symbol(SYM_W'(s));
    end
    run_burst(BURST_LEN);

    // Same table under back-pressure
    bp_on = 1'b1;
    run_burst(BURST_LEN);

    // Rewrite about half the table, then run again
    for (int s = 0; s < NUM_SYM; s++) begin
      if (rand_bits(1) != 0) config_symbol(SYM_W'(s));
    end
    run_burst(BURST_LEN);

    $display("Errors: %0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src/strategy_engine.sv */
// --------------------------------------
// Strategy stage top level. Decoder
// packets in, stamped orders out, host
// settings through the config port.
// --------------------------------------

module strategy_engine
  import t2t_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  // Host configuration
  input  logic               cfg_wr,
  input  logic [SYM_W-1:0]   cfg_sym,
  input  cfg_field_e         cfg_field,
  input  logic [DATA_W-1:0]  cfg_wdata,
  // Decoder stream
  input  logic               dec_valid,
  input  logic               dec_sop,
  input  logic [DATA_W-1:0]  dec_data,
  output logic               dec_ready,
  // Order stream
  input  logic               order_ready,
  output logic               order_valid,
  output logic [OID_W-1:0]   order_id,
  output logic [SYM_W-1:0]   order_sym,
  output logic [PRICE_W-1:0] order_price,
  output logic [VOL_W-1:0]   order_qty
);

  // Register block to FSM and datapath
  logic               rd_en;
  logic [SYM_W-1:0]   rd_sym;
  logic               sym_enable;
  logic [PRICE_W-1:0] price_limit;
  logic [VOL_W-1:0]   min_volume;
  logic [VOL_W-1:0]   order_qty_cfg;
  // Comparator control and results
  logic               pcmp_load_a;
  logic               pcmp_load_b;
  logic               vcmp_load_a;
  logic               vcmp_load_b;
  logic               price_ok;
  logic               volume_ok;
  // Stamp handshake
  logic               stamp_req;
  logic               stamp_go;
  logic               stamp_done;

  strategy_regs u_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_wr        (cfg_wr),
    .cfg_sym       (cfg_sym),
    .cfg_field     (cfg_field),
    .cfg_wdata     (cfg_wdata),
    .rd_en         (rd_en),
    .rd_sym        (rd_sym),
    .sym_enable    (sym_enable),
    .price_limit   (price_limit),
    .min_volume    (min_volume),
    .order_qty_cfg (order_qty_cfg)
  );

  strategy_fsm u_fsm (
    .clk         (clk),
    .reset_n     (reset_n),
    .dec_valid   (dec_valid),
    .dec_sop     (dec_sop),
    .dec_data    (dec_data),
    .dec_ready   (dec_ready),
    .rd_en       (rd_en),
    .rd_sym      (rd_sym),
    .sym_enable  (sym_enable),
    .price_ok    (price_ok),
    .volume_ok   (volume_ok),
    .pcmp_load_a (pcmp_load_a),
    .pcmp_load_b (pcmp_load_b),
    .vcmp_load_a (vcmp_load_a),
    .vcmp_load_b (vcmp_load_b),
    .stamp_req   (stamp_req),
    .stamp_go    (stamp_go),
    .stamp_done  (stamp_done)
  );

  // Message price against the limit
  threshold_cmp #(.W(PRICE_W)) u_price_cmp (
    .clk     (clk),
    .reset_n (reset_n),
    .load_a  (pcmp_load_a),
    .load_b  (pcmp_load_b),
    .a_in    (dec_data[PRICE_W-1:0]),
    .b_in    (price_limit),
    .a_le_b  (price_ok)
  );

  // Minimum volume against the message volume
  threshold_cmp #(.W(VOL_W)) u_volume_cmp (
    .clk     (clk),
    .reset_n (reset_n),
    .load_a  (vcmp_load_a),
    .load_b  (vcmp_load_b),
    .a_in    (min_volume),
    .b_in    (dec_data[VOL_W-1:0]),
    .a_le_b  (volume_ok)
  );

  order_stamp u_stamp (
    .clk           (clk),
    .reset_n       (reset_n),
    .stamp_req     (stamp_req),
    .stamp_go      (stamp_go),
    .sym_in        (dec_data[SYM_HI:SYM_LO]),
    .price_in      (dec_data[PRICE_W-1:0]),
    .volume_in     (dec_data[VOL_W-1:0]),
    .order_qty_cfg (order_qty_cfg),
    .order_ready   (order_ready),
    .order_valid   (order_valid),
    .order_id      (order_id),
    .order_sym     (order_sym),
    .order_price   (order_price),
    .order_qty     (order_qty),
    .stamp_done    (stamp_done)
  );

endmodule

/* src/order_stamp.sv */
// --------------------------------------
// Order builder. Captures symbol and
// price on beat 1, sizes the quantity on
// launch, numbers the order and holds it
// until the order stream takes it.
// --------------------------------------

module order_stamp
  import t2t_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  logic               stamp_req,
  input  logic               stamp_go,
  input  logic [SYM_W-1:0]   sym_in,
  input  logic [PRICE_W-1:0] price_in,
  input  logic [VOL_W-1:0]   volume_in,
  input  logic [VOL_W-1:0]   order_qty_cfg,
  // Order stream
  input  logic               order_ready,
  output logic               order_valid,
  output logic [OID_W-1:0]   order_id,
  output logic [SYM_W-1:0]   order_sym,
  output logic [PRICE_W-1:0] order_price,
  output logic [VOL_W-1:0]   order_qty,
  output logic               stamp_done
);

  logic [VOL_W-1:0] vol_q;
  logic [VOL_W-1:0] qty_nxt;
  logic [OID_W-1:0] id_q;

  // Smaller of traded volume and configured size
  assign qty_nxt = (vol_q < order_qty_cfg) ? vol_q : order_qty_cfg;

  assign stamp_done = order_valid & order_ready;
  assign order_id   = id_q;

  // --------------------------------------
  // Payload
  // --------------------------------------

  always_ff @(posedge clk) begin
    // Beat-2 volume delayed one cycle to line up with the compare cycle
    if (!order_valid) vol_q <= volume_in;
    if (stamp_req) begin
      order_sym   <= sym_in;
      order_price <= price_in;
    end
    if (stamp_go) order_qty <= qty_nxt;
  end

  // --------------------------------------
  // Valid and order id
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      order_valid <= 1'b0;
      id_q        <= '0;
    end else begin
      if (stamp_go)        order_valid <= 1'b1;
      else if (stamp_done) order_valid <= 1'b0;
      // Next id only after the current one is taken
      if (stamp_done) id_q <= id_q + 1'b1;
    end
  end

  // Fields frozen under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
    order_valid && !order_ready |=> order_valid && $stable(order_id) &&
      $stable(order_sym) && $stable(order_price) && $stable(order_qty));

endmodule

/* src/strategy_fsm.sv */
// --------------------------------------
// Strategy execution FSM. Takes decoder
// packets, reads the symbol settings,
// loads both comparators and launches
// the order stamp when both pass.
// --------------------------------------

module strategy_fsm
  import t2t_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  // Decoder stream
  input  logic              dec_valid,
  input  logic              dec_sop,
  input  logic [DATA_W-1:0] dec_data,
  output logic              dec_ready,
  // Settings read
  output logic              rd_en,
  output logic [SYM_W-1:0]  rd_sym,
  input  logic              sym_enable,
  // Comparators
  input  logic              price_ok,
  input  logic              volume_ok,
  output logic              pcmp_load_a,
  output logic              pcmp_load_b,
  output logic              vcmp_load_a,
  output logic              vcmp_load_b,
  // Order stamp
  output logic              stamp_req,
  output logic              stamp_go,
  input  logic              stamp_done
);

  sef_state_e state;
  sef_state_e state_nxt;
  msg_type_e  msg_type;
  logic       new_msg;
  logic       beat2_acc;

  // Beat 1 fields
  assign msg_type = msg_type_e'(dec_data[MSG_TYPE_HI:MSG_TYPE_LO]);
  assign rd_sym   = dec_data[SYM_HI:SYM_LO];
  assign new_msg  = dec_valid & dec_sop & (msg_type == MSG_NEW);

  // Ready in ST_LD only for a beat 2 of an enabled symbol;
  // anything else is left for ST_WAIT to discard or restart on
  assign dec_ready = (state == ST_WAIT) |
                     ((state == ST_LD) & sym_enable & ~dec_sop);

  assign beat2_acc = (state == ST_LD) & sym_enable & dec_valid & ~dec_sop;

  // Read, price A and stamp capture all fire on NEW beat 1
  assign rd_en       = (state == ST_WAIT) & new_msg;
  assign pcmp_load_a = rd_en;
  assign stamp_req   = rd_en;

  // Limit arrives from the register block in ST_LD
  assign pcmp_load_b = (state == ST_LD);
  // Min volume and message volume together
  assign vcmp_load_a = beat2_acc;
  assign vcmp_load_b = beat2_acc;

  assign stamp_go = (state == ST_CMP) & price_ok & volume_ok;

  // --------------------------------------
  // State machine
  // --------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      ST_WAIT: begin
        if (new_msg) state_nxt = ST_LD;
      end
      ST_LD: begin
        // Abort on a disabled symbol or a new packet in place of beat 2
        if (!sym_enable || (dec_valid && dec_sop)) state_nxt = ST_WAIT;
        else if (beat2_acc)                        state_nxt = ST_CMP;
      end
      ST_CMP: begin
        state_nxt = (price_ok && volume_ok) ? ST_ISSUE : ST_WAIT;
      end
      ST_ISSUE: begin
        if (stamp_done) state_nxt = ST_WAIT;
      end
      default: state_nxt = ST_WAIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= ST_WAIT;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------
  // Assertions
  // --------------------------------------

  // A settings read never starts while the stamper still holds an order
  a_rd_from_wait: assert property (@(posedge clk) disable iff (!reset_n)
    rd_en |-> !stamp_done);

  // The stamper reports a taken order only while the FSM holds in ST_ISSUE
  a_issue_hold: assert property (@(posedge clk) disable iff (!reset_n)
    stamp_done |-> (state == ST_ISSUE));

endmodule

/* src/threshold_cmp.sv */
// --------------------------------------
// Two-operand threshold compare. A and B
// load on their own strobes; output is
// A <= B on the stored values.
// --------------------------------------

module threshold_cmp
  import t2t_pkg::*;
#(
  parameter int W = PRICE_W
) (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         load_a,
  input  logic         load_b,
  input  logic [W-1:0] a_in,
  input  logic [W-1:0] b_in,
  output logic         a_le_b
);

  logic [W-1:0] a_q;
  logic [W-1:0] b_q;

  // Operands may arrive in different cycles
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      if (load_a) a_q <= a_in;
      if (load_b) b_q <= b_in;
    end
  end

  // Unsigned compare
  assign a_le_b = (a_q <= b_q);

endmodule

/* src/strategy_regs.sv */
// --------------------------------------
// Per-symbol strategy settings. Host
// writes one field per cycle; the FSM
// reads a whole symbol, registered.
// --------------------------------------

module strategy_regs
  import t2t_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  // Host write port
  input  logic               cfg_wr,
  input  logic [SYM_W-1:0]   cfg_sym,
  input  cfg_field_e         cfg_field,
  input  logic [DATA_W-1:0]  cfg_wdata,
  // FSM read port
  input  logic               rd_en,
  input  logic [SYM_W-1:0]   rd_sym,
  output logic               sym_enable,
  output logic [PRICE_W-1:0] price_limit,
  output logic [VOL_W-1:0]   min_volume,
  output logic [VOL_W-1:0]   order_qty_cfg
);

  // Settings table, one entry per symbol
  logic [NUM_SYM-1:0] enable_q;
  logic [PRICE_W-1:0] price_limit_q [NUM_SYM];
  logic [VOL_W-1:0]   min_volume_q  [NUM_SYM];
  logic [VOL_W-1:0]   order_qty_q   [NUM_SYM];

  // --------------------------------------
  // Host writes
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      // All symbols start disabled with zero settings
      enable_q <= '0;
      for (int i = 0; i < NUM_SYM; i++) begin
        price_limit_q[i] <= '0;
        min_volume_q[i]  <= '0;
        order_qty_q[i]   <= '0;
      end
    end else if (cfg_wr) begin
      case (cfg_field)
        FLD_ENABLE:      enable_q[cfg_sym]      <= cfg_wdata[0];
        FLD_PRICE_LIMIT: price_limit_q[cfg_sym] <= cfg_wdata[PRICE_W-1:0];
        FLD_MIN_VOLUME:  min_volume_q[cfg_sym]  <= cfg_wdata[VOL_W-1:0];
        FLD_ORDER_QTY:   order_qty_q[cfg_sym]   <= cfg_wdata[VOL_W-1:0];
        default: ;
      endcase
    end
  end

  // --------------------------------------
  // Registered read
  // --------------------------------------

  // Held while rd_en is low, so data stays valid until beat 2 shows up
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sym_enable    <= 1'b0;
      price_limit   <= '0;
      min_volume    <= '0;
      order_qty_cfg <= '0;
    end else if (rd_en) begin
      sym_enable    <= enable_q[rd_sym];
      price_limit   <= price_limit_q[rd_sym];
      min_volume    <= min_volume_q[rd_sym];
      order_qty_cfg <= order_qty_q[rd_sym];
    end
  end

endmodule

/* src/t2t_pkg.sv */
// --------------------------------------
// Shared widths, beat layout and enums
// for the strategy stage. Imported by
// every RTL module of the engine.
// --------------------------------------

package t2t_pkg;

  // --------------------------------------
  // Widths
  // --------------------------------------

  // Decoder beat
  localparam int DATA_W  = 32;
  // Symbol index and table depth
  localparam int SYM_W   = 4;
  localparam int NUM_SYM = 16;
  // Order payload fields
  localparam int PRICE_W = 16;
  localparam int VOL_W   = 16;
  localparam int OID_W   = 16;

  // --------------------------------------
  // Beat 1 layout
  // --------------------------------------

  // Message type in the top two bits
  localparam int MSG_TYPE_HI = 31;
  localparam int MSG_TYPE_LO = 30;
  // Symbol index just below it
  localparam int SYM_HI = 29;
  localparam int SYM_LO = 26;
  // Price in the low half, volume in the low half of beat 2

  // --------------------------------------
  // Enums
  // --------------------------------------

  typedef enum logic [1:0] {
    MSG_NEW    = 2'd0,
    MSG_TRADE  = 2'd1,
    MSG_CANCEL = 2'd2,
    MSG_OTHER  = 2'd3
  } msg_type_e;

  // Strategy execution FSM
  typedef enum logic [1:0] {
    ST_WAIT,
    ST_LD,
    ST_CMP,
    ST_ISSUE
  } sef_state_e;

  // Host register field select
  typedef enum logic [1:0] {
    FLD_ENABLE      = 2'd0,
    FLD_PRICE_LIMIT = 2'd1,
    FLD_MIN_VOLUME  = 2'd2,
    FLD_ORDER_QTY   = 2'd3
  } cfg_field_e;

endpackage
